/* files.f */
+incdir+.
tcb_pkg.sv
tcb_mem_sub.sv
tcb_reg_sub.sv
tcb_dec.sv
tcb_sys.sv
tcb_properties.sv
tcb_tb.sv

/* run.sh */
#!/bin/sh
# build the TCB testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tcb_tb \
  -f files.f -o tcb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tcb_sim > sim.log 2>&1
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* tcb_dec.sv */
`include "tcb_params.svh"

module tcb_dec (
  input  logic               tcb,
  input  logic               arst_n,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output tcb_pkg::tcb_rsp_t  rsp,
  output tcb_pkg::tcb_req_t  mem_req,
  output tcb_pkg::tcb_req_t  reg_req,
  input  logic               mem_rdy,
  input  tcb_pkg::tcb_rsp_t  mem_rsp,
  input  logic               reg_rdy,
  input  tcb_pkg::tcb_rsp_t  reg_rsp
);

  import tcb_pkg::*;

  ////////////////////
  // address decode
  ////////////////////

  localparam logic [`TCB_ABW-1:0] mem_base = `TCB_MEM_BASE;
  localparam logic [`TCB_ABW-1:0] reg_base = `TCB_REG_BASE;

  tcb_tgt_e tgt;      // target of the current request
  tcb_tgt_e rsp_tgt;  // target of the response now due
  logic     rsp_vld;  // a response is due now
  logic     self_rdy; // own ready for unmapped addresses
  logic     trn;

  // compare the bits above the region
  always_comb begin
    if (req.adr[`TCB_ABW-1:`TCB_RGN_AW] == mem_base[`TCB_ABW-1:`TCB_RGN_AW]) begin
      tgt = TGT_MEM;
    end else if (req.adr[`TCB_ABW-1:`TCB_RGN_AW] == reg_base[`TCB_ABW-1:`TCB_RGN_AW]) begin
      tgt = TGT_REG;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // request fan out, vld only toward the selected target
  always_comb begin
    mem_req     = req;
    reg_req     = req;
    mem_req.vld = req.vld & (tgt == TGT_MEM);
    reg_req.vld = req.vld & (tgt == TGT_REG);
  end

  // unmapped space is always ready after reset
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      self_rdy <= 1'b0;
    end else begin
      self_rdy <= 1'b1;
    end
  end

  always_comb begin
    case (tgt)
      TGT_MEM: rdy = mem_rdy;
      TGT_REG: rdy = reg_rdy;
      default: rdy = self_rdy;
    endcase
  end

  assign trn = req.vld & rdy;

  ////////////////////
  // target pipeline
  ////////////////////

  if (`TCB_DLY == 0) begin : g_comb

    assign rsp_tgt = tgt;
    assign rsp_vld = trn;

  end else begin : g_pipe

    tcb_tgt_e pip_tgt [0:`TCB_DLY-1];
    logic     pip_vld [0:`TCB_DLY-1];

    always_ff @(posedge tcb or negedge arst_n) begin
      if (!arst_n) begin
        for (int i = 0; i < `TCB_DLY; i++) begin
          pip_tgt[i] <= TGT_NONE;
          pip_vld[i] <= 1'b0;
        end
      end else begin
        pip_tgt[0] <= tgt;
        pip_vld[0] <= trn;
        for (int i = 1; i < `TCB_DLY; i++) begin
          pip_tgt[i] <= pip_tgt[i-1];
          pip_vld[i] <= pip_vld[i-1];
        end
      end
    end

    assign rsp_tgt = pip_tgt[`TCB_DLY-1];
    assign rsp_vld = pip_vld[`TCB_DLY-1];

  end

  // response mux, unmapped answers with err and zero data
  always_comb begin
    case (rsp_tgt)
      TGT_MEM: rsp = mem_rsp;
      TGT_REG: rsp = reg_rsp;
      default: begin
        rsp.rdt = '0;
        rsp.err = rsp_vld;
      end
    endcase
  end

endmodule

/* tcb_mem_sub.sv */
`include "tcb_params.svh"

module tcb_mem_sub (
  input  logic               tcb,
  input  logic               arst_n,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output tcb_pkg::tcb_rsp_t  rsp
);

  import tcb_pkg::*;

  ////////////////////
  // local signals
  ////////////////////

  localparam int unsigned mem_dep = 2**`TCB_MEM_AW;

  // storage, word addressed
  logic [`TCB_DBW-1:0]    mem [0:mem_dep-1];
  // word index inside the region
  logic [`TCB_MEM_AW-1:0] idx;
  // address past the memory depth
  logic                   oob;
  // transfer
  logic                   trn;

  assign idx = req.adr[`TCB_MEM_AW+1:2];
  // any region bit above the word index set
  assign oob = |req.adr[`TCB_RGN_AW-1:`TCB_MEM_AW+2];
  assign trn = req.vld & rdy;

  ////////////////////
  // ready
  ////////////////////

  // low in reset, then always ready
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////
  // storage write
  ////////////////////

  // byte lanes written only where enabled
  always_ff @(posedge tcb) begin
    if (trn && req.wen && !oob) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // response pipeline
  ////////////////////

  if (`TCB_DLY == 0) begin : g_comb

    // same cycle answer, async read
    assign rsp.rdt = (trn && !req.wen && !oob) ? mem[idx] : '0;
    assign rsp.err = trn & oob;

  end else begin : g_pipe

    logic                pip_vld [0:`TCB_DLY-1];
    logic                pip_wen [0:`TCB_DLY-1];
    logic [`TCB_DBW-1:0] pip_rdt [0:`TCB_DLY-1];
    logic                pip_err [0:`TCB_DLY-1];

    // valid bits only
    always_ff @(posedge tcb or negedge arst_n) begin
      if (!arst_n) begin
        for (int i = 0; i < `TCB_DLY; i++) begin
          pip_vld[i] <= 1'b0;
        end
      end else begin
        pip_vld[0] <= trn;
        for (int i = 1; i < `TCB_DLY; i++) begin
          pip_vld[i] <= pip_vld[i-1];
        end
      end
    end

    // payload, first stage loads on a transfer
    always_ff @(posedge tcb) begin
      if (trn) begin
        pip_wen[0] <= req.wen;
        pip_rdt[0] <= (req.wen || oob) ? '0 : mem[idx];
        pip_err[0] <= oob;
      end
      for (int i = 1; i < `TCB_DLY; i++) begin
        pip_wen[i] <= pip_wen[i-1];
        pip_rdt[i] <= pip_rdt[i-1];
        pip_err[i] <= pip_err[i-1];
      end
    end

    // last stage, data only for reads
    assign rsp.rdt = (pip_vld[`TCB_DLY-1] && !pip_wen[`TCB_DLY-1]) ?
                     pip_rdt[`TCB_DLY-1] : '0;
    assign rsp.err = pip_vld[`TCB_DLY-1] & pip_err[`TCB_DLY-1];

  end

endmodule

/* tcb_params.svh */
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

////////////////////
// bus widths
////////////////////

`define TCB_ABW 32
`define TCB_DBW 32
// one enable per byte lane
`define TCB_BEW (`TCB_DBW/8)

// response delay in cycles, 0 to 3
`define TCB_DLY 1

////////////////////
// address map
////////////////////

// memory depth as word address width
`define TCB_MEM_AW 8
// each region spans 4 KB
`define TCB_RGN_AW 12
`define TCB_MEM_BASE 32'h0000_0000
`define TCB_REG_BASE 32'h0000_1000
// read-only id register contents
`define TCB_REG_ID 32'h7cb5_0a01

`endif

/* tcb_pkg.sv */
`include "tcb_params.svh"

package tcb_pkg;

  ////////////////////
  // request
  ////////////////////

  // manager driven request, all fields qualified by vld
  typedef struct packed {
    logic                vld;  // request valid
    logic                wen;  // write enable
    logic [`TCB_ABW-1:0] adr;  // byte address
    logic [`TCB_BEW-1:0] ben;  // byte enables
    logic [`TCB_DBW-1:0] wdt;  // write data
    logic                lck;  // lock, carried only
    logic                rpt;  // repeat, carried only
  } tcb_req_t;

  ////////////////////
  // response
  ////////////////////

  // returned TCB_DLY cycles after the transfer
  typedef struct packed {
    logic [`TCB_DBW-1:0] rdt;  // read data, zero for writes
    logic                err;  // error for reads and writes
  } tcb_rsp_t;

  ////////////////////
  // decoder target
  ////////////////////

  typedef enum logic [1:0] {
    TGT_MEM  = 2'd0,
    TGT_REG  = 2'd1,
    TGT_NONE = 2'd2
  } tcb_tgt_e;

endpackage

/* tcb_properties.sv */
`include "tcb_params.svh"

module tcb_properties (
  input logic              tcb,
  input logic              arst_n,
  input tcb_pkg::tcb_req_t req,
  input logic              rdy,
  input tcb_pkg::tcb_rsp_t rsp,
  input tcb_pkg::tcb_req_t mem_req,
  input tcb_pkg::tcb_req_t reg_req,
  input tcb_pkg::tcb_rsp_t mem_rsp,
  input tcb_pkg::tcb_rsp_t reg_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  import tcb_pkg::*;

  tcb_tgt_e tgt;

  // target as seen from the gated requests
  assign tgt = mem_req.vld ? TGT_MEM : (reg_req.vld ? TGT_REG : TGT_NONE);

  ////////////////////
  // handshake
  ////////////////////

  // stalled request holds still
  a_hold: assert property (@(posedge tcb) disable iff (!arst_n)
    (req.vld && !rdy) |=> $stable(req))
    else $error("request changed while the bus was not ready");

  // never both subordinates at once
  a_one: assert property (@(posedge tcb) disable iff (!arst_n)
    !(mem_req.vld && reg_req.vld))
    else $error("both subordinates selected");

  ////////////////////
  // response routing
  ////////////////////

  a_mem: assert property (@(posedge tcb) disable iff (!arst_n)
    (req.vld && rdy && tgt == TGT_MEM) |-> ##`TCB_DLY (rsp == mem_rsp))
    else $error("memory response not forwarded at the delayed target");

  a_reg: assert property (@(posedge tcb) disable iff (!arst_n)
    (req.vld && rdy && tgt == TGT_REG) |-> ##`TCB_DLY (rsp == reg_rsp))
    else $error("register response not forwarded at the delayed target");

  // unmapped, error and no data
  a_none: assert property (@(posedge tcb) disable iff (!arst_n)
    (req.vld && rdy && tgt == TGT_NONE) |-> ##`TCB_DLY (rsp.err && rsp.rdt == '0))
    else $error("unmapped transfer answered without error");

endmodule

bind tcb_dec tcb_properties u_props (
  .tcb(tcb), .arst_n(arst_n), .req(req), .rdy(rdy), .rsp(rsp),
  .mem_req(mem_req), .reg_req(reg_req), .mem_rsp(mem_rsp), .reg_rsp(reg_rsp)
);

/* tcb_reg_sub.sv */
`include "tcb_params.svh"

module tcb_reg_sub (
  input  logic                tcb,
  input  logic                arst_n,
  input  tcb_pkg::tcb_req_t   req,
  output logic                rdy,
  output tcb_pkg::tcb_rsp_t   rsp,
  output logic [`TCB_DBW-1:0] gpio
);

  import tcb_pkg::*;

  ////////////////////
  // local signals
  ////////////////////

  localparam logic [`TCB_DBW-1:0] id_word = `TCB_REG_ID;

  logic [`TCB_DBW-1:0] scr [0:1];  // scratch pair
  logic [1:0]          off;        // word offset
  logic                err_now;    // error for this request
  logic [`TCB_DBW-1:0] rd_word;    // read mux
  logic                trn;
  logic                wr_ok;

  assign off = req.adr[3:2];
  // unused offsets, and id writes
  assign err_now = (|req.adr[`TCB_RGN_AW-1:4]) | (req.wen & (off == 2'd0));
  assign trn     = req.vld & rdy;
  assign wr_ok   = trn & req.wen & ~err_now;

  // ready after reset
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////
  // registers
  ////////////////////

  // gpio at offset 1
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      gpio <= '0;
    end else if (wr_ok && off == 2'd1) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (req.ben[b]) begin
          gpio[8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  // scratch at offsets 2 and 3
  always_ff @(posedge tcb) begin
    if (wr_ok && off[1]) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (req.ben[b]) begin
          scr[off[0]][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    case (off)
      2'd0:    rd_word = id_word;
      2'd1:    rd_word = gpio;
      default: rd_word = scr[off[0]];
    endcase
  end

  ////////////////////
  // response pipeline
  ////////////////////

  if (`TCB_DLY == 0) begin : g_comb

    assign rsp.rdt = (trn && !req.wen && !err_now) ? rd_word : '0;
    assign rsp.err = trn & err_now;

  end else begin : g_pipe

    logic                pip_vld [0:`TCB_DLY-1];
    logic [`TCB_DBW-1:0] pip_rdt [0:`TCB_DLY-1];
    logic                pip_err [0:`TCB_DLY-1];

    always_ff @(posedge tcb or negedge arst_n) begin
      if (!arst_n) begin
        for (int i = 0; i < `TCB_DLY; i++) begin
          pip_vld[i] <= 1'b0;
        end
      end else begin
        pip_vld[0] <= trn;
        for (int i = 1; i < `TCB_DLY; i++) begin
          pip_vld[i] <= pip_vld[i-1];
        end
      end
    end

    // write flag folded into zeroed read data
    always_ff @(posedge tcb) begin
      if (trn) begin
        pip_rdt[0] <= (req.wen || err_now) ? '0 : rd_word;
        pip_err[0] <= err_now;
      end
      for (int i = 1; i < `TCB_DLY; i++) begin
        pip_rdt[i] <= pip_rdt[i-1];
        pip_err[i] <= pip_err[i-1];
      end
    end

    assign rsp.rdt = pip_vld[`TCB_DLY-1] ? pip_rdt[`TCB_DLY-1] : '0;
    assign rsp.err = pip_vld[`TCB_DLY-1] & pip_err[`TCB_DLY-1];

  end

endmodule

/* tcb_sys.sv */
`include "tcb_params.svh"

module tcb_sys (
  input  logic                tcb,
  input  logic                arst_n,
  input  tcb_pkg::tcb_req_t   req,
  output logic                rdy,
  output tcb_pkg::tcb_rsp_t   rsp,
  output logic [`TCB_DBW-1:0] gpio
);

  import tcb_pkg::*;

  ////////////////////
  // decoder to subordinates
  ////////////////////

  tcb_req_t mem_req;
  tcb_req_t reg_req;
  logic     mem_rdy;
  logic     reg_rdy;
  tcb_rsp_t mem_rsp;
  tcb_rsp_t reg_rsp;

  tcb_dec u_dec (
    .tcb(tcb), .arst_n(arst_n),
    .req(req), .rdy(rdy), .rsp(rsp),
    .mem_req(mem_req), .reg_req(reg_req),
    .mem_rdy(mem_rdy), .mem_rsp(mem_rsp),
    .reg_rdy(reg_rdy), .reg_rsp(reg_rsp)
  );

  // 4 KB memory region
  tcb_mem_sub u_mem (
    .tcb(tcb), .arst_n(arst_n),
    .req(mem_req), .rdy(mem_rdy), .rsp(mem_rsp)
  );

  // id, gpio and scratch
  tcb_reg_sub u_reg (
    .tcb(tcb), .arst_n(arst_n),
    .req(reg_req), .rdy(reg_rdy), .rsp(reg_rsp),
    .gpio(gpio)
  );

endmodule

/* tcb_tb.sv */
`include "tcb_params.svh"

module tcb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import tcb_pkg::*;

  // expected response, due at a given cycle
  typedef struct {
    int       due;
    tcb_rsp_t rsp;
    string    name;
  } exp_t;

  logic                tcb;
  logic                arst_n;
  tcb_req_t            req;
  logic                rdy;
  tcb_rsp_t            rsp;
  logic [`TCB_DBW-1:0] gpio;

  // reference model
  logic [`TCB_DBW-1:0] mem_m [0:2**`TCB_MEM_AW-1];
  logic [`TCB_DBW-1:0] scr_m [0:1];
  logic [`TCB_DBW-1:0] gpio_m = '0;
  exp_t                pend [$];
  string               test = "reset";
  int                  cyc = 0;
  int                  checks = 0;
  int                  errors = 0;
  logic                timed_out = 1'b0;

  tcb_sys DUT (
    .tcb(tcb), .arst_n(arst_n), .req(req), .rdy(rdy), .rsp(rsp), .gpio(gpio)
  );

  initial begin
    tcb = 1'b0;
    forever #50 tcb = ~tcb;
  end

  // values shown as {rdt, err}
  task automatic report(string name, logic [32:0] exp, logic [32:0] act);
    errors++;
    $display("ERROR %s: expected %h actual %h", name, exp, act);
  endtask

  task automatic timeout(string what);
    $display("timeout, %s", what);
    timed_out = 1'b1;
    // calling thread parks here for good
    forever @(posedge tcb);
  endtask

  // ends the run once any wait has given up
  initial begin
    wait (timed_out);
    $display("%0d checks, %0d errors, run timed out", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////
  // reference model
  ////////////////////

  // response of one transfer, state updated in order of transfers
  function automatic tcb_rsp_t model(tcb_req_t r);
    tcb_rsp_t               o;
    logic [`TCB_DBW-1:0]    m;
    logic [`TCB_MEM_AW-1:0] w;
    o = '0;
    w = r.adr[`TCB_MEM_AW+1:2];
    // byte lane mask
    for (int b = 0; b < `TCB_BEW; b++) begin
      m[8*b +: 8] = {8{r.ben[b]}};
    end
    if ((r.adr >> `TCB_RGN_AW) == (`TCB_MEM_BASE >> `TCB_RGN_AW)) begin
      // only the low words of the region are backed
      if (int'(r.adr[`TCB_RGN_AW-1:2]) >= 2**`TCB_MEM_AW) begin
        o.err = 1'b1;
      end else if (r.wen) begin
        mem_m[w] = (mem_m[w] & ~m) | (r.wdt & m);
      end else begin
        o.rdt = mem_m[w];
      end
    end else if ((r.adr >> `TCB_RGN_AW) == (`TCB_REG_BASE >> `TCB_RGN_AW)) begin
      // id, gpio, two scratch words, nothing past offset 3
      if (int'(r.adr[`TCB_RGN_AW-1:2]) > 3 || (r.adr[3:2] == 2'd0 && r.wen)) begin
        o.err = 1'b1;
      end else if (r.wen && r.adr[3:2] == 2'd1) begin
        gpio_m = (gpio_m & ~m) | (r.wdt & m);
      end else if (r.wen) begin
        scr_m[r.adr[2]] = (scr_m[r.adr[2]] & ~m) | (r.wdt & m);
      end else begin
        case (r.adr[3:2])
          2'd0:    o.rdt = `TCB_REG_ID;
          2'd1:    o.rdt = gpio_m;
          default: o.rdt = scr_m[r.adr[2]];
        endcase
      end
    end else begin
      o.err = 1'b1;
    end
    return o;
  endfunction

  ////////////////////
  // monitor
  ////////////////////

  // mid cycle, request and response settled
  always @(negedge tcb) begin
    exp_t e;
    cyc++;
    if (!arst_n) begin
      // not ready while in reset
      assert (rdy === 1'b0) else report({test, " rdy"}, 33'd0, {32'd0, rdy});
    end else begin
      // gpio carries every write up to the last edge
      assert (gpio === gpio_m)
        else report({test, " gpio"}, {gpio_m, 1'b0}, {gpio, 1'b0});
      if (req.vld && rdy) begin
        e.due  = cyc + `TCB_DLY;
        e.rsp  = model(req);
        e.name = test;
        pend.push_back(e);
      end
      checks++;
      if (pend.size() > 0 && pend[0].due == cyc) begin
        e = pend.pop_front();
        assert (rsp === e.rsp) else report(e.name, e.rsp, rsp);
      end else begin
        // nothing due, bus stays quiet
        assert (rsp === '0) else report({test, " idle"}, '0, rsp);
      end
    end
  end

  // driven just after the edge, held until accepted
  task automatic xfer(logic wen, logic [`TCB_ABW-1:0] adr, logic [31:0] ben,
                      logic [`TCB_DBW-1:0] wdt);
    int n;
    req.vld = 1'b1;
    req.wen = wen;
    req.adr = adr;
    req.ben = ben[`TCB_BEW-1:0];
    req.wdt = wdt;
    req.lck = $urandom_range(0, 1) == 1;
    req.rpt = 1'b0;
    n = 0;
    do begin
      @(negedge tcb);
      n++;
      if (n > 8) timeout("request never accepted");
    end while (!rdy);
    @(posedge tcb);
    #1;
    req.vld = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pend.size() > 0) begin
      @(posedge tcb);
      #1;
      n++;
      if (n > 8) timeout("responses still pending");
    end
  endtask

  initial begin
    logic [`TCB_ABW-1:0] a;
    int                  n;
    void'($urandom(32'h81d9e923));
    req    = '0;
    arst_n = 1'b0;
    repeat (3) @(posedge tcb);
    #1;
    arst_n = 1'b1;
    n = 0;
    while (!rdy) begin
      @(posedge tcb);
      #1;
      n++;
      if (n > 8) timeout("ready did not rise after reset");
    end
    // gpio read straight after reset
    xfer(1'b0, `TCB_REG_BASE + 32'h4, '1, '0);
    // fill, pattern from the whole address
    test = "mem_fill";
    for (int i = 0; i < 2**`TCB_MEM_AW; i++) begin
      a = `TCB_MEM_BASE + (i << 2);
      xfer(1'b1, a, '1, a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9);
    end
    // random byte writes, each read back
    test = "mem_bytes";
    repeat (150) begin
      a = `TCB_MEM_BASE + ($urandom_range(0, 2**`TCB_MEM_AW - 1) << 2);
      xfer(1'b1, a, $urandom, $urandom);
      xfer(1'b0, a, '1, $urandom);
    end
    // scratch full words first so every bit is known
    test = "regs";
    xfer(1'b1, `TCB_REG_BASE + 32'h8, '1, $urandom);
    xfer(1'b1, `TCB_REG_BASE + 32'hc, '1, $urandom);
    repeat (24) begin
      a = `TCB_REG_BASE + ($urandom_range(1, 3) << 2);
      xfer(1'b1, a, $urandom, $urandom);
      xfer(1'b0, a, '1, '0);
      xfer(1'b0, `TCB_REG_BASE, '1, '0);
    end
    // one transfer per cycle over both regions
    test = "mix";
    repeat (300) begin
      if ($urandom_range(0, 1) == 1) begin
        a = `TCB_MEM_BASE + ($urandom_range(0, 2**`TCB_MEM_AW - 1) << 2);
      end else begin
        a = `TCB_REG_BASE + ($urandom_range(1, 3) << 2);
      end
      xfer($urandom_range(0, 1) == 1, a, $urandom, $urandom);
    end
    // error writes, then reads of what they could have hit
    test = "errors";
    xfer(1'b1, `TCB_REG_BASE, '1, $urandom);
    // unused offset, aliases scratch 0 in the low bits
    xfer(1'b1, `TCB_REG_BASE + 32'h18, '1, $urandom);
    xfer(1'b1, `TCB_MEM_BASE + 32'h400, '1, $urandom);
    xfer(1'b1, 32'h0000_2000, '1, $urandom);
    xfer(1'b0, `TCB_REG_BASE, '1, '0);
    xfer(1'b0, `TCB_REG_BASE + 32'h8, '1, '0);
    xfer(1'b0, `TCB_REG_BASE + 32'h7fc, '1, '0);
    xfer(1'b0, `TCB_MEM_BASE + 32'hffc, '1, '0);
    xfer(1'b0, `TCB_MEM_BASE, '1, '0);
    xfer(1'b0, 32'hdead_beec, '1, '0);
    xfer(1'b0, `TCB_REG_BASE + 32'h4, '1, '0);
    drain();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
